// File: hw/vic_pkg.sv
`default_nettype none

package vic_pkg;

    // chip model select, matches the two config pins of the real board
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6567r56a = 2'd1,
        chip_6569     = 2'd2
    } chip_t;

    // line length in cycles and frame height in lines per chip
    localparam logic [8:0] CYCLES_R8   = 9'd65;
    localparam logic [8:0] CYCLES_R56A = 9'd64;
    localparam logic [8:0] CYCLES_6569 = 9'd63;
    localparam logic [8:0] LINES_R8    = 9'd263;
    localparam logic [8:0] LINES_R56A  = 9'd262;
    localparam logic [8:0] LINES_6569  = 9'd312;

    // sync widths, hsync in cycles and vsync in lines
    localparam logic [8:0] HSYNC_LEN   = 9'd4;
    localparam logic [8:0] VSYNC_LINES = 9'd3;

    // display window, start inclusive and end exclusive
    localparam logic [8:0] ACTIVE_X_START = 9'd12;
    localparam logic [8:0] ACTIVE_X_END   = 9'd52;
    localparam logic [8:0] ACTIVE_Y_START = 9'd51;
    localparam logic [8:0] ACTIVE_Y_END   = 9'd251;

    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
    } raster_t;

    // cpu visible register map
    localparam logic [5:0] REG_CTRL       = 6'h11;
    localparam logic [5:0] REG_RASTER     = 6'h12;
    localparam logic [5:0] REG_IRQ_STATUS = 6'h19;
    localparam logic [5:0] REG_IRQ_ENABLE = 6'h1a;
    localparam logic [5:0] REG_BORDER     = 6'h20;
    localparam logic [5:0] REG_BACKGROUND = 6'h21;
    localparam logic [7:0] RD_UNMAPPED    = 8'hff;

    // ce is active low, rw high means the cpu reads
    typedef struct packed {
        logic       ce;
        logic       rw;
        logic [5:0] adi;
        logic [7:0] dbi;
    } cpu_bus_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // classic 16 colour palette, rounded to 4 bits per channel
    localparam rgb_t PALETTE [0:15] = '{
        12'h000, 12'hfff, 12'h833, 12'h6cc,
        12'h848, 12'h5a4, 12'h439, 12'hbc7,
        12'h852, 12'h540, 12'hb66, 12'h555,
        12'h777, 12'h9e8, 12'h76c, 12'h999
    };

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } report_t;

    // credit link and serial settings
    localparam int TX_CREDITS = 4;
    localparam int UART_DIV   = 8;
    localparam int CREDIT_W   = $clog2(TX_CREDITS + 1);
    localparam int PTR_W      = $clog2(TX_CREDITS);
    localparam int BAUD_W     = $clog2(UART_DIV);

endpackage

`default_nettype wire

// File: hw/raster_timing.sv
`default_nettype none

module raster_timing (
    input  wire              sys_clock,
    input  wire              rst_n,
    input  vic_pkg::chip_t   chip,
    output vic_pkg::raster_t pos,
    output logic             line_start,
    output logic             hsync,
    output logic             vsync,
    output logic             active
);
    import vic_pkg::*;

    logic [8:0] x;
    logic [8:0] y;
    logic [8:0] line_len;
    logic [8:0] frame_h;
    logic       x_wrap;
    logic       y_wrap;

    // geometry per chip model
    always_comb begin
        case (chip)
            chip_6567r8: begin
                line_len = CYCLES_R8;
                frame_h  = LINES_R8;
            end
            chip_6567r56a: begin
                line_len = CYCLES_R56A;
                frame_h  = LINES_R56A;
            end
            default: begin
                line_len = CYCLES_6569;
                frame_h  = LINES_6569;
            end
        endcase
    end

    // >= so a chip change mid line still wraps cleanly
    assign x_wrap = (x >= line_len - 9'd1);
    assign y_wrap = (y >= frame_h - 9'd1);

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (x_wrap) begin
            x <= '0;
            y <= y_wrap ? 9'd0 : y + 9'd1;
        end else begin
            x <= x + 9'd1;
        end
    end

    assign pos = '{x: x, y: y};

    // all decodes come straight off the registered counters
    assign line_start = (x == 9'd0);
    assign hsync      = (x < HSYNC_LEN);
    assign vsync      = (y < VSYNC_LINES);
    assign active     = (x >= ACTIVE_X_START) && (x < ACTIVE_X_END) &&
                        (y >= ACTIVE_Y_START) && (y < ACTIVE_Y_END);

endmodule

`default_nettype wire

// File: hw/register_bank.sv
`default_nettype none

module register_bank (
    input  wire               sys_clock,
    input  wire               rst_n,
    input  vic_pkg::cpu_bus_t bus,
    input  vic_pkg::raster_t  pos,
    input  wire               line_start,
    output logic [7:0]        dbo,
    output logic              db_drive,
    output logic              irq,
    output logic [3:0]        border_idx,
    output logic [3:0]        background_idx
);
    import vic_pkg::*;

    logic [8:0] raster_cmp;
    logic [6:0] ctrl_bits;
    logic       irq_raster;
    logic [3:0] irq_enable;
    logic       wr_en;
    logic       raster_hit;
    logic       irq_any;

    assign wr_en      = !bus.ce && !bus.rw;
    assign raster_hit = line_start && (pos.y == raster_cmp);

    // only the raster source exists, so status is a single bit
    assign irq_any = irq_raster && irq_enable[0];

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            raster_cmp     <= '0;
            ctrl_bits      <= '0;
            irq_raster     <= 1'b0;
            irq_enable     <= '0;
            border_idx     <= '0;
            background_idx <= '0;
        end else begin
            if (wr_en) begin
                case (bus.adi)
                    REG_CTRL: begin
                        // bit 7 is compare bit 8
                        raster_cmp[8] <= bus.dbi[7];
                        ctrl_bits     <= bus.dbi[6:0];
                    end
                    REG_RASTER:     raster_cmp[7:0] <= bus.dbi;
                    REG_IRQ_ENABLE: irq_enable      <= bus.dbi[3:0];
                    REG_BORDER:     border_idx      <= bus.dbi[3:0];
                    REG_BACKGROUND: background_idx  <= bus.dbi[3:0];
                    default: ;
                endcase
            end
            // write one to clear, a new hit in the same cycle wins
            if (raster_hit) begin
                irq_raster <= 1'b1;
            end else if (wr_en && bus.adi == REG_IRQ_STATUS && bus.dbi[0]) begin
                irq_raster <= 1'b0;
            end
        end
    end

    // reads are combinational, raster regs return the live line
    always_comb begin
        case (bus.adi)
            REG_CTRL:       dbo = {pos.y[8], ctrl_bits};
            REG_RASTER:     dbo = pos.y[7:0];
            REG_IRQ_STATUS: dbo = {irq_any, 6'b0, irq_raster};
            REG_IRQ_ENABLE: dbo = {4'b0, irq_enable};
            REG_BORDER:     dbo = {4'b0, border_idx};
            REG_BACKGROUND: dbo = {4'b0, background_idx};
            default:        dbo = RD_UNMAPPED;
        endcase
    end

    assign db_drive = !bus.ce && bus.rw;

    // active low line to the cpu
    assign irq = !irq_any;

endmodule

`default_nettype wire

// File: hw/color_output.sv
`default_nettype none

module color_output (
    input  vic_pkg::raster_t pos,
    input  wire [3:0]        border_idx,
    input  wire [3:0]        background_idx,
    output vic_pkg::rgb_t    rgb
);
    import vic_pkg::*;

    logic       in_window;
    logic [3:0] color_idx;

    // same window as the active output of the timing block
    assign in_window = (pos.x >= ACTIVE_X_START) && (pos.x < ACTIVE_X_END) &&
                       (pos.y >= ACTIVE_Y_START) && (pos.y < ACTIVE_Y_END);

    // background inside the window, border everywhere else
    assign color_idx = in_window ? background_idx : border_idx;

    // palette lookup
    assign rgb = PALETTE[color_idx];

endmodule

`default_nettype wire

// File: hw/status_reporter.sv
`default_nettype none

module status_reporter (
    input  wire               sys_clock,
    input  wire               rst_n,
    input  vic_pkg::raster_t  pos,
    input  wire               line_start,
    input  wire               credit_return,
    output vic_pkg::report_t  push
);
    import vic_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                can_push;
    logic                push_valid;
    logic [7:0]          push_data;

    // a line with no free credit is simply skipped
    assign can_push = line_start && (credits != '0);

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            credits    <= CREDIT_W'(TX_CREDITS);
            push_valid <= 1'b0;
        end else begin
            push_valid <= can_push;
            // a push and a return in the same cycle cancel out
            case ({can_push, credit_return})
                2'b10:   credits <= credits - CREDIT_W'(1);
                2'b01:   credits <= credits + CREDIT_W'(1);
                default: credits <= credits;
            endcase
        end
    end

    // low byte of the line just started
    always_ff @(posedge sys_clock) begin
        if (can_push) begin
            push_data <= pos.y[7:0];
        end
    end

    assign push = '{valid: push_valid, data: push_data};

endmodule

`default_nettype wire

// File: hw/tx_fifo.sv
`default_nettype none

module tx_fifo (
    input  wire              sys_clock,
    input  wire              rst_n,
    input  vic_pkg::report_t push,
    input  wire              take,
    output vic_pkg::report_t head,
    output logic             credit_return
);
    import vic_pkg::*;

    logic [7:0]          mem [TX_CREDITS];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count;

    // storage, the credit scheme keeps writes off a full queue
    always_ff @(posedge sys_clock) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.data;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(TX_CREDITS - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(TX_CREDITS - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({push.valid, take})
                2'b10:   count <= count + CREDIT_W'(1);
                2'b01:   count <= count - CREDIT_W'(1);
                default: count <= count;
            endcase
            // one credit back per pop
            credit_return <= take;
        end
    end

    // show-ahead head entry
    assign head = '{valid: (count != '0), data: mem[rd_ptr]};

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`default_nettype none

module uart_tx (
    input  wire              sys_clock,
    input  wire              rst_n,
    input  vic_pkg::report_t head,
    output logic             take,
    output logic             tx
);
    import vic_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } uart_state_t;

    uart_state_t       state;
    logic [BAUD_W-1:0] baud;
    logic [2:0]        bit_idx;
    logic [7:0]        shift;
    logic              baud_tick;

    assign baud_tick = (baud == BAUD_W'(UART_DIV - 1));

    // pop the fifo head whenever the line is free
    assign take = (state == st_idle) && head.valid;

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            state   <= st_idle;
            baud    <= '0;
            bit_idx <= '0;
        end else begin
            baud <= (state == st_idle || baud_tick) ? '0 : baud + BAUD_W'(1);
            case (state)
                st_idle:  if (take) state <= st_start;
                st_start: if (baud_tick) state <= st_data;
                st_data: begin
                    if (baud_tick) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end
                end
                st_stop:  if (baud_tick) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // data byte, shifted out lsb first
    always_ff @(posedge sys_clock) begin
        if (take) begin
            shift <= head.data;
        end else if (state == st_data && baud_tick) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    // line idles high, start bit low, one stop bit high
    assign tx = (state == st_start) ? 1'b0 :
                (state == st_data)  ? shift[0] : 1'b1;

endmodule

`default_nettype wire

// File: hw/vic_top.sv
`default_nettype none

module vic_top (
    input  wire               sys_clock,
    input  wire               rst_n,
    input  vic_pkg::chip_t    chip,
    input  vic_pkg::cpu_bus_t bus,
    output logic [7:0]        dbo,
    output logic              db_drive,
    output logic              irq,
    output logic              hsync,
    output logic              vsync,
    output logic              active,
    output vic_pkg::rgb_t     rgb,
    output logic              tx
);
    import vic_pkg::*;

    raster_t    pos;
    logic       line_start;
    logic [3:0] border_idx;
    logic [3:0] background_idx;
    report_t    push;
    report_t    head;
    logic       credit_return;
    logic       take;

    // counters and sync decode
    raster_timing u_raster_timing (
        .sys_clock  (sys_clock),
        .rst_n      (rst_n),
        .chip       (chip),
        .pos        (pos),
        .line_start (line_start),
        .hsync      (hsync),
        .vsync      (vsync),
        .active     (active)
    );

    // cpu side, dbo plus drive enable instead of a tristate bus
    register_bank u_register_bank (
        .sys_clock      (sys_clock),
        .rst_n          (rst_n),
        .bus            (bus),
        .pos            (pos),
        .line_start     (line_start),
        .dbo            (dbo),
        .db_drive       (db_drive),
        .irq            (irq),
        .border_idx     (border_idx),
        .background_idx (background_idx)
    );

    color_output u_color_output (
        .pos            (pos),
        .border_idx     (border_idx),
        .background_idx (background_idx),
        .rgb            (rgb)
    );

    // status link, reporter to fifo runs on credits
    status_reporter u_status_reporter (
        .sys_clock     (sys_clock),
        .rst_n         (rst_n),
        .pos           (pos),
        .line_start    (line_start),
        .credit_return (credit_return),
        .push          (push)
    );

    tx_fifo u_tx_fifo (
        .sys_clock     (sys_clock),
        .rst_n         (rst_n),
        .push          (push),
        .take          (take),
        .head          (head),
        .credit_return (credit_return)
    );

    uart_tx u_uart_tx (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .head      (head),
        .take      (take),
        .tx        (tx)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    input  wire  reset_req,
    output logic sys_clock,
    output logic rst_n
);
    logic [1:0] hold;

    // free running clock, 40 units per period
    initial begin
        sys_clock = 1'b0;
        hold      = 2'd3;
        forever #20 sys_clock = ~sys_clock;
    end

    // reset low for three rising edges, at start and on each request
    always @(posedge sys_clock) begin
        if (reset_req) begin
            hold <= 2'd3;
        end else if (hold != 2'd0) begin
            hold <= hold - 2'd1;
        end
    end

    assign rst_n = (hold == 2'd0);

endmodule

`default_nettype wire

// File: test/tb_vic_top.sv
`default_nettype none

module tb_vic_top;
    import vic_pkg::*;

    logic        sys_clock;
    logic        rst_n;
    logic        reset_req;
    chip_t       chip;
    cpu_bus_t    bus;
    logic [7:0]  dbo;
    logic        db_drive;
    logic        irq;
    logic        hsync;
    logic        vsync;
    logic        active;
    rgb_t        rgb;
    logic        tx;

    // case file contents with one entry per command line
    logic [7:0]  cmd_q [$];
    logic [11:0] a_q [$];
    logic [11:0] b_q [$];
    logic [11:0] c_q [$];
    logic [7:0]  cmd;
    logic [11:0] op1;
    logic [11:0] op2;
    logic [11:0] op3;
    logic [7:0]  rd;
    string       text;
    int          fd;
    int          idx;
    int          long_cmds;
    int          limit;
    int          value_errors;
    int          other_errors;

    // raster tracking seen from the sync pins
    int          cycles;
    int          frames;
    int          line_no;
    int          cur_cycles;
    int          cur_lines;
    logic        hsync_q;
    logic        vsync_q;

    tb_clock_gen u_tb_clock_gen (
        .reset_req (reset_req),
        .sys_clock (sys_clock),
        .rst_n     (rst_n)
    );

    vic_top u_vic_top (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .chip      (chip),
        .bus       (bus),
        .dbo       (dbo),
        .db_drive  (db_drive),
        .irq       (irq),
        .hsync     (hsync),
        .vsync     (vsync),
        .active    (active),
        .rgb       (rgb),
        .tx        (tx)
    );

    function automatic cpu_bus_t idle_bus();
        return '{ce: 1'b1, rw: 1'b1, adi: 6'd0, dbi: 8'd0};
    endfunction

    task automatic check_value(input string name, input int exp, input int got);
        assert (exp == got) else begin
            $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_condition(input logic ok, input string what);
        assert (ok) else begin
            $display("%0t: %s", $time, what);
            other_errors++;
        end
    endtask

    // line counter follows hsync rises and restarts on vsync and on reset
    always @(posedge sys_clock) begin
        hsync_q <= hsync;
        vsync_q <= vsync;
        cycles  <= cycles + 1;
        if (!rst_n) begin
            line_no <= 0;
        end else if (hsync && !hsync_q) begin
            line_no <= (vsync && !vsync_q) ? 0 : line_no + 1;
        end
        if (vsync && !vsync_q) begin
            frames <= frames + 1;
        end
        if (cycles >= limit) begin
            $display("timeout: the run exceeded %0d clock cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    // new chip model followed by a full reset of the DUT
    task automatic apply_chip(input logic [1:0] sel, input int len, input int height);
        @(posedge sys_clock);
        chip      <= chip_t'(sel);
        reset_req <= 1'b1;
        @(posedge sys_clock);
        reset_req <= 1'b0;
        @(negedge sys_clock);
        while (!rst_n) @(negedge sys_clock);
        cur_cycles = len;
        cur_lines  = height;
    endtask

    task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
        @(posedge sys_clock);
        bus <= '{ce: 1'b0, rw: 1'b0, adi: addr, dbi: data};
        @(negedge sys_clock);
        check_value("db_drive", 0, db_drive);
        // write lands on this edge
        @(posedge sys_clock);
        bus <= idle_bus();
    endtask

    task automatic bus_read(input logic [5:0] addr, output logic [7:0] data);
        @(posedge sys_clock);
        bus <= '{ce: 1'b0, rw: 1'b1, adi: addr, dbi: 8'h00};
        @(negedge sys_clock);
        check_value("db_drive", 1, db_drive);
        data = dbo;
        @(posedge sys_clock);
        bus <= idle_bus();
        @(negedge sys_clock);
        check_value("db_drive", 0, db_drive);
    endtask

    // line and frame lengths from sync edges and colour against active
    task automatic check_frames(input int count, input logic [11:0] border_rgb,
                                input logic [11:0] back_rgb);
        int          seen;
        int          clocks;
        int          lines;
        int          high_len;
        int          act_cnt;
        int          act_want;
        logic        have_h;
        logic        have_v;
        logic        prev_h;
        logic        prev_v;
        logic        rgb_bad;
        logic [11:0] want;
        seen     = 0;
        clocks   = 0;
        lines    = 0;
        high_len = 0;
        act_cnt  = 0;
        // display window is 40 columns by 200 lines on every chip
        act_want = int'(ACTIVE_X_END - ACTIVE_X_START) *
                   int'(ACTIVE_Y_END - ACTIVE_Y_START);
        have_h   = 1'b0;
        have_v   = 1'b0;
        rgb_bad  = 1'b0;
        @(negedge sys_clock);
        prev_h = hsync;
        prev_v = vsync;
        // first vsync rise only sets the reference
        while (seen <= count) begin
            @(negedge sys_clock);
            clocks++;
            if (vsync && !prev_v) begin
                if (have_v) begin
                    check_value("lines per frame", cur_lines, lines);
                    check_value("active clocks per frame", act_want, act_cnt);
                end
                have_v  = 1'b1;
                lines   = 0;
                act_cnt = 0;
                seen++;
            end
            if (hsync && !prev_h) begin
                if (have_h) begin
                    check_value("clocks per line", cur_cycles, clocks);
                end
                have_h   = 1'b1;
                clocks   = 0;
                high_len = 0;
                lines++;
            end
            if (hsync) begin
                high_len++;
            end
            if (active) begin
                act_cnt++;
            end
            if (!hsync && prev_h && have_h) begin
                check_value("hsync length", HSYNC_LEN, high_len);
            end
            // colour follows the active window
            want = active ? back_rgb : border_rgb;
            if (!rgb_bad && rgb !== want) begin
                check_value("rgb", want, rgb);
                rgb_bad = 1'b1;
            end
            prev_h = hsync;
            prev_v = vsync;
        end
    endtask

    task automatic check_irq(input logic [8:0] target, input logic enabled);
        int         start;
        logic [7:0] ctrl_rd;
        logic [7:0] raster_rd;
        logic [7:0] status_rd;
        bus_write(REG_IRQ_STATUS, 8'h01);
        @(negedge sys_clock);
        if (enabled) begin
            while (irq) @(negedge sys_clock);
            bus_read(REG_CTRL, ctrl_rd);
            bus_read(REG_RASTER, raster_rd);
            check_value("irq line", target, {ctrl_rd[7], raster_rd});
            bus_read(REG_IRQ_STATUS, status_rd);
            check_value("irq status", 8'h81, status_rd);
            // irq has to survive into the next line
            while (!hsync && !irq) @(negedge sys_clock);
            check_value("irq", 0, irq);
        end else begin
            start = frames;
            while (frames - start < 2 && irq) @(negedge sys_clock);
            check_value("irq", 1, irq);
            bus_read(REG_IRQ_STATUS, status_rd);
            check_value("irq status", 8'h01, status_rd);
        end
        bus_write(REG_IRQ_STATUS, 8'h01);
        @(negedge sys_clock);
        check_value("irq", 1, irq);
    endtask

    // 8N1 decode at the pin with samples taken in the middle of each bit
    task automatic collect_bytes(input int count);
        int         got;
        int         i;
        int         k;
        int         cand;
        int         res;
        int         step;
        int         prev_res;
        int         last_end;
        logic [7:0] data;
        logic       found;
        got      = 0;
        prev_res = -1;
        last_end = cycles;
        @(negedge sys_clock);
        while (got < count) begin
            while (tx) @(negedge sys_clock);
            // move from the first start cycle to the middle of the bit
            repeat (UART_DIV / 2) @(negedge sys_clock);
            check_condition(!tx, "start bit on tx ended early");
            for (i = 0; i < 8; i++) begin
                repeat (UART_DIV) @(negedge sys_clock);
                data[i] = tx;
            end
            repeat (UART_DIV) @(negedge sys_clock);
            check_condition(tx, "stop bit missing on tx");
            // queue depth bounds the lag to a few lines
            found = 1'b0;
            res   = 0;
            for (k = 0; k <= 8 && !found; k++) begin
                cand = (line_no - k + cur_lines) % cur_lines;
                if (cand[7:0] == data) begin
                    found = 1'b1;
                    res   = cand;
                end
            end
            check_condition(found, "serial byte matches no recent raster line");
            if (found && prev_res >= 0) begin
                step = (res - prev_res + cur_lines) % cur_lines;
                // a step back wraps to nearly a whole frame
                check_condition(step >= 1 && step <= 8,
                                "serial bytes arrived out of line order");
            end
            check_condition(cycles - last_end <= 5 * cur_cycles,
                            "no serial byte within five lines");
            prev_res = found ? res : -1;
            last_end = cycles;
            got++;
        end
    endtask

    initial begin
        chip         = chip_6569;
        bus          = idle_bus();
        reset_req    = 1'b0;
        cycles       = 0;
        frames       = 0;
        line_no      = 0;
        hsync_q      = 1'b0;
        vsync_q      = 1'b0;
        cur_cycles   = 63;
        cur_lines    = 312;
        long_cmds    = 0;
        value_errors = 0;
        other_errors = 0;
        fd = $fopen("test/vic_cases.txt", "r");
        if (fd == 0) begin
            check_condition(1'b0, "cannot open test/vic_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() < 2 || text[0] == "#") begin
                    continue;
                end
                cmd = 8'h00;
                op1 = '0;
                op2 = '0;
                // mask for R when left out
                op3 = 12'h0ff;
                void'($sscanf(text, "%c %h %h %h", cmd, op1, op2, op3));
                cmd_q.push_back(cmd);
                a_q.push_back(op1);
                b_q.push_back(op2);
                c_q.push_back(op3);
                if (cmd == "F" || cmd == "Q" || cmd == "S") begin
                    long_cmds++;
                end
            end
            $fclose(fd);
        end
        // three of the longest frames per long command plus one for startup
        limit = (long_cmds * 3 + 1) * 312 * 65;
        @(negedge sys_clock);
        while (!rst_n) @(negedge sys_clock);
        for (idx = 0; idx < cmd_q.size(); idx++) begin
            case (cmd_q[idx])
                "C": apply_chip(a_q[idx][1:0], b_q[idx], c_q[idx]);
                "W": bus_write(a_q[idx][5:0], b_q[idx][7:0]);
                "R": begin
                    bus_read(a_q[idx][5:0], rd);
                    check_value("dbo", b_q[idx][7:0], rd & c_q[idx][7:0]);
                end
                "F": check_frames(a_q[idx], b_q[idx], c_q[idx]);
                "Q": check_irq(a_q[idx][8:0], b_q[idx][0]);
                "S": collect_bytes(a_q[idx]);
                default: check_condition(1'b0, "unknown command in the case file");
            endcase
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/vic_cases.txt
# hex operands: C chip cycles lines | W addr data | R addr expected [mask]
# F frames border_rgb background_rgb | Q line irq_enable | S bytes (right after C)
C 2 3f 138
W 1a 01
R 1a 01
W 20 0e
W 21 06
R 20 0e
R 21 06
W 11 85
R 11 05 7f
R 3f ff
R 00 ff
F 1 76c 439
W 12 04
Q 104 1
C 0 41 107
W 20 02
W 21 0d
F 1 833 9e8
W 12 20
W 1a 01
Q 20 1
W 1a 00
Q 20 0
C 1 40 106
S c
F 1 000 000
C 2 3f 138
S 8

// File: list.f
hw/vic_pkg.sv
hw/raster_timing.sv
hw/register_bank.sv
hw/color_output.sv
hw/status_reporter.sv
hw/tx_fifo.sv
hw/uart_tx.sv
hw/vic_top.sv
test/tb_clock_gen.sv
test/tb_vic_top.sv

// File: Bender.yml
package:
  name: vic_core

sources:
  - files:
      - hw/vic_pkg.sv
      - hw/raster_timing.sv
      - hw/register_bank.sv
      - hw/color_output.sv
      - hw/status_reporter.sv
      - hw/tx_fifo.sv
      - hw/uart_tx.sv
      - hw/vic_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_vic_top.sv
